//--- include/mm_params.svh
`ifndef MM_PARAMS_SVH
`define MM_PARAMS_SVH

// array is MM_DIM x MM_DIM cells
`define MM_DIM 4

// signed matrix element width
`define MM_DATA_W 8

// accumulator width, wide enough for 255 full-scale products
`define MM_ACC_W 32

// width of the run length field, runs of 1 to 255 steps
`define MM_KLEN_W 8

// zero flush after the last step
// last product needs 2N-1 enabled cycles to reach the far corner
`define MM_DRAIN (2 * `MM_DIM)

`endif

//--- hw/mm_pkg.sv
`include "mm_params.svh"

////////////////////////////////////////////////////////////////////////////
// shared element types of the matrix engine
////////////////////////////////////////////////////////////////////////////

package mm_pkg;

  // one signed int8 matrix element
  typedef logic signed [`MM_DATA_W-1:0] elem_t;

  // one signed accumulator word of a result cell
  typedef logic signed [`MM_ACC_W-1:0] acc_t;

  // one column of A or one row of B
  // element 0 sits in the low bits
  typedef elem_t [`MM_DIM-1:0] elem_vec_t;

endpackage

//--- hw/skew_regs.sv
`timescale 1ns/1ps
`include "mm_params.svh"

// staggered delay bank for the array edge
// lane i comes out i+1 enabled cycles after it went in
module skew_regs #(
  parameter int lanes = `MM_DIM
) (
  input  logic                         clk,
  input  logic                         en,
  input  mm_pkg::elem_t [lanes-1:0]    din,
  output mm_pkg::elem_t [lanes-1:0]    dout
);

  ////////////////////////////////////////////////////////////////////////////
  // one delay chain per lane
  ////////////////////////////////////////////////////////////////////////////

  genvar lane;

  generate
    for (lane = 0; lane < lanes; lane = lane + 1) begin : g_lane

      // stage 0 takes the input
      // stage lane is the output register
      mm_pkg::elem_t pipe [lane+1];

      always_ff @(posedge clk) begin
        if (en) begin
          pipe[0] <= din[lane];
          for (int s = 1; s <= lane; s++) begin
            pipe[s] <= pipe[s-1];
          end
        end
      end

      assign dout[lane] = pipe[lane];

    end
  endgenerate

endmodule

//--- hw/mac_pe.sv
`timescale 1ns/1ps
`include "mm_params.svh"

// one output-stationary systolic cell
// a moves east, b moves south, the product stays here
module mac_pe (
  input  logic          clk,
  input  logic          en,
  input  logic          clear,
  input  mm_pkg::elem_t a_in,
  input  mm_pkg::elem_t b_in,
  output mm_pkg::elem_t a_out,
  output mm_pkg::elem_t b_out,
  output mm_pkg::acc_t  acc
);

  // full precision signed product
  logic signed [2*`MM_DATA_W-1:0] prod;

  assign prod = a_in * b_in;

  // operands for the east and south neighbours
  always_ff @(posedge clk) begin
    if (en) begin
      a_out <= a_in;
      b_out <= b_in;
    end
  end

  // clear wins over a step
  always_ff @(posedge clk) begin
    if (clear) begin
      acc <= '0;
    end else if (en) begin
      acc <= acc + prod;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  // a stalled cell must not drift while results are being read
  a_acc_hold: assert property (
    @(posedge clk) (!en && !clear) |=> $stable(acc)
  );

endmodule

//--- hw/mac_array.sv
`timescale 1ns/1ps
`include "mm_params.svh"

// N x N grid of mac cells with a row read mux
module mac_array (
  input  logic                              clk,
  input  logic                              en,
  input  logic                              clear,
  input  mm_pkg::elem_vec_t                 a_left,
  input  mm_pkg::elem_vec_t                 b_top,
  input  logic [$clog2(`MM_DIM)-1:0]        rd_row,
  output mm_pkg::acc_t [`MM_DIM-1:0]        rd_data
);

  // horizontal a links, column N is the unused east edge
  mm_pkg::elem_t a_h [`MM_DIM][`MM_DIM+1];
  // vertical b links, row N is the unused south edge
  mm_pkg::elem_t b_v [`MM_DIM+1][`MM_DIM];
  // one packed accumulator row per array row
  mm_pkg::acc_t [`MM_DIM-1:0] acc_row [`MM_DIM];

  genvar i;
  genvar j;

  ////////////////////////////////////////////////////////////////////////////
  // grid
  ////////////////////////////////////////////////////////////////////////////

  generate
    for (i = 0; i < `MM_DIM; i = i + 1) begin : g_row
      // west and north edges come from the skew banks
      assign a_h[i][0] = a_left[i];
      assign b_v[0][i] = b_top[i];

      for (j = 0; j < `MM_DIM; j = j + 1) begin : g_col
        mac_pe i_pe (
          .clk   (clk),
          .en    (en),
          .clear (clear),
          .a_in  (a_h[i][j]),
          .b_in  (b_v[i][j]),
          .a_out (a_h[i][j+1]),
          .b_out (b_v[i+1][j]),
          .acc   (acc_row[i][j])
        );
      end
    end
  endgenerate

  // result row picked by rd_row
  assign rd_data = acc_row[rd_row];

endmodule

//--- hw/mm_ctrl.sv
`timescale 1ns/1ps
`include "mm_params.svh"

// run control of the matrix engine
// idle -> load for k_len accepted steps -> drain -> idle with done
module mm_ctrl (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    start,
  input  logic [`MM_KLEN_W-1:0]   k_len,
  input  logic                    in_valid,
  input  mm_pkg::elem_vec_t       a_col,
  input  mm_pkg::elem_vec_t       b_row,
  output logic                    busy,
  output logic                    done,
  output logic                    in_ready,
  output logic                    step_en,
  output logic                    acc_clear,
  output mm_pkg::elem_vec_t       a_feed,
  output mm_pkg::elem_vec_t       b_feed
);

  localparam int drain_w = $clog2(`MM_DRAIN);

  localparam logic [1:0] st_idle  = 2'd0;
  localparam logic [1:0] st_load  = 2'd1;
  localparam logic [1:0] st_drain = 2'd2;

  logic [1:0]            state;
  logic [`MM_KLEN_W-1:0] k_len_q;
  logic [`MM_KLEN_W-1:0] step_cnt;
  logic [drain_w-1:0]    drain_cnt;
  logic                  feed_zero;
  logic                  accept;

  ////////////////////////////////////////////////////////////////////////////
  // handshake and pipeline controls
  ////////////////////////////////////////////////////////////////////////////

  assign busy      = (state != st_idle);
  assign in_ready  = (state == st_load) && (step_cnt < k_len_q);
  assign accept    = in_valid && in_ready;
  assign feed_zero = (state == st_drain);

  // pipeline moves only on a real step or a flush cycle
  assign step_en   = accept || feed_zero;
  // clears at the start edge so the first load step is kept
  assign acc_clear = start && !busy;

  // zeros into both skew banks while flushing
  assign a_feed = feed_zero ? '0 : a_col;
  assign b_feed = feed_zero ? '0 : b_row;

  ////////////////////////////////////////////////////////////////////////////
  // state machine
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= st_idle;
      k_len_q   <= '0;
      step_cnt  <= '0;
      drain_cnt <= '0;
      done      <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        st_idle: begin
          if (start) begin
            k_len_q   <= k_len;
            step_cnt  <= '0;
            drain_cnt <= '0;
            // empty run goes straight to the flush
            state     <= (k_len == '0) ? st_drain : st_load;
          end
        end
        st_load: begin
          if (accept) begin
            step_cnt <= step_cnt + 1'b1;
            if (step_cnt == k_len_q - 1'b1) begin
              state <= st_drain;
            end
          end
        end
        st_drain: begin
          drain_cnt <= drain_cnt + 1'b1;
          if (drain_cnt == drain_w'(`MM_DRAIN - 1)) begin
            state <= st_idle;
            done  <= 1'b1;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  a_done_pulse: assert property (
    @(posedge clk) disable iff (reset) done |=> !done
  );

  // ready falls with the last accepted step
  // so nothing past k_len is taken once load is over
  a_ready_in_load: assert property (
    @(posedge clk) disable iff (reset)
      (accept && step_cnt == k_len_q - 1'b1) |=> !in_ready
  );

  // a start during a run leaves the stored length alone
  a_start_busy: assert property (
    @(posedge clk) disable iff (reset) (start && busy) |=> $stable(k_len_q)
  );

endmodule

//--- hw/mm_top.sv
`timescale 1ns/1ps
`include "mm_params.svh"

// int8 matrix multiply engine, C = A x B on an N x N systolic grid
module mm_top (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          start,
  input  logic [`MM_KLEN_W-1:0]         k_len,
  input  logic                          in_valid,
  output logic                          in_ready,
  input  mm_pkg::elem_vec_t             a_col,
  input  mm_pkg::elem_vec_t             b_row,
  output logic                          busy,
  output logic                          done,
  input  logic [$clog2(`MM_DIM)-1:0]    rd_row,
  output mm_pkg::acc_t [`MM_DIM-1:0]    rd_data
);

  logic              step_en;
  logic              acc_clear;
  mm_pkg::elem_vec_t a_feed;
  mm_pkg::elem_vec_t b_feed;
  mm_pkg::elem_vec_t a_skew;
  mm_pkg::elem_vec_t b_skew;

  mm_ctrl i_ctrl (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .k_len     (k_len),
    .in_valid  (in_valid),
    .a_col     (a_col),
    .b_row     (b_row),
    .busy      (busy),
    .done      (done),
    .in_ready  (in_ready),
    .step_en   (step_en),
    .acc_clear (acc_clear),
    .a_feed    (a_feed),
    .b_feed    (b_feed)
  );

  // A columns onto the west edge, row i delayed i+1 steps
  skew_regs #(.lanes(`MM_DIM)) i_skew_a (.clk(clk), .en(step_en), .din(a_feed), .dout(a_skew));

  // B rows onto the north edge, column j delayed j+1 steps
  skew_regs #(.lanes(`MM_DIM)) i_skew_b (.clk(clk), .en(step_en), .din(b_feed), .dout(b_skew));

  mac_array i_array (
    .clk     (clk),
    .en      (step_en),
    .clear   (acc_clear),
    .a_left  (a_skew),
    .b_top   (b_skew),
    .rd_row  (rd_row),
    .rd_data (rd_data)
  );

endmodule

//--- dv/mm_checker.sv
`timescale 1ns/1ps
`include "mm_params.svh"

// watches the engine ports, checks the run protocol and compares results
module mm_checker (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          start,
  input  logic [`MM_KLEN_W-1:0]         k_len,
  input  logic                          in_valid,
  input  logic                          in_ready,
  input  logic                          busy,
  input  logic                          done,
  input  mm_pkg::acc_t [`MM_DIM-1:0]    rd_data,
  output logic [$clog2(`MM_DIM)-1:0]    rd_row,
  output logic                          reading
);

  localparam int n     = `MM_DIM;
  localparam int max_k = 1 << `MM_KLEN_W;
  localparam int row_w = $clog2(`MM_DIM);

  int               exp_c [n][n];
  bit               exp_check = 1'b0;
  int               run_klen = 0;
  int               steps = 0;
  int               pending = 0;
  int               row_idx = 0;
  int               data_cnt = 0;
  int               proto_cnt = 0;
  logic [row_w-1:0] row_sel = '0;
  logic             read_on = 1'b0;

  assign rd_row  = row_sel;
  assign reading = read_on;

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  // signed C[i][j] = sum over s of A[i][s] * B[s][j]
  function automatic void reference_product(
    input mm_pkg::elem_t a_m [n][max_k],
    input mm_pkg::elem_t b_m [max_k][n],
    input int            k
  );
    int sum;
    for (int i = 0; i < n; i++) begin
      for (int j = 0; j < n; j++) begin
        sum = 0;
        for (int s = 0; s < k; s++) begin
          sum = sum + int'(a_m[i][s]) * int'(b_m[s][j]);
        end
        exp_c[i][j] = sum;
      end
    end
  endfunction

  // called by the testbench before each start
  task automatic expect_run(
    input int            k,
    input bit            check,
    input mm_pkg::elem_t a_m [n][max_k],
    input mm_pkg::elem_t b_m [max_k][n]
  );
    reference_product(a_m, b_m, k);
    exp_check = check;
  endtask

  task automatic flag_protocol(input string msg);
    $display("protocol failure at %0d ns: %s", $time, msg);
    proto_cnt = proto_cnt + 1;
  endtask

  task automatic final_check(output int data_errs, output int proto_errs);
    if (pending != 0) begin
      flag_protocol("a run was still waiting for done at the end");
    end
    data_errs  = data_cnt;
    proto_errs = proto_cnt;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // protocol watch and result read-out
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!reset) begin
      if (in_ready && !busy) begin
        flag_protocol("in_ready high while the engine is idle");
      end
      if (busy && pending == 0) begin
        flag_protocol("busy high without an accepted start");
      end
      // busy rises the cycle after start and falls together with done
      if (pending != 0 && !busy && !done) begin
        flag_protocol("busy low in the middle of a run");
      end
      if (done && busy) begin
        flag_protocol("busy still high in the done cycle");
      end

      // done is handled first
      // a start in the done cycle opens the next run
      if (done) begin
        if (pending == 0) begin
          flag_protocol("done without an accepted start");
        end else begin
          pending = pending - 1;
        end
        if (steps != run_klen) begin
          flag_protocol($sformatf("run took %0d steps instead of %0d", steps, run_klen));
        end
        row_idx = 0;
        row_sel <= '0;
        read_on <= 1'b1;
      end else if (read_on) begin
        for (int c = 0; c < n; c++) begin
          if (exp_check && rd_data[c] !== mm_pkg::acc_t'(exp_c[row_idx][c])) begin
            $display("Error at %0d ns: rd_data[%0d][%0d] expected %0d, actual %0d",
                     $time, row_idx, c, exp_c[row_idx][c], rd_data[c]);
            data_cnt = data_cnt + 1;
          end
        end
        if (row_idx == n - 1) begin
          read_on <= 1'b0;
        end else begin
          row_idx = row_idx + 1;
          row_sel <= row_w'(row_idx);
        end
      end

      if (start && !busy) begin
        if (pending != 0) begin
          flag_protocol("new start before the previous run reported done");
        end
        pending  = pending + 1;
        run_klen = int'(k_len);
        steps    = 0;
      end

      if (in_valid && in_ready) begin
        steps = steps + 1;
        if (steps > run_klen) begin
          flag_protocol("input accepted beyond k_len steps");
        end
      end
    end
  end

endmodule

//--- dv/mm_tb.sv
`timescale 1ns/1ps
`include "mm_params.svh"

module mm_tb;

  localparam int n          = `MM_DIM;
  localparam int max_k      = 1 << `MM_KLEN_W;
  localparam int klen_w     = `MM_KLEN_W;
  localparam int clk_period = 8;
  localparam int num_tests  = 10;

  localparam mm_pkg::elem_t elem_min = 8'sh80;
  localparam mm_pkg::elem_t elem_max = 8'sh7f;

  // fill: 0 random, 1 keep last matrices, 2 A=-128 B=127, 3 all -128
  // first run has zero length and only flushes the unreset pipeline
  int test_klen  [num_tests] = '{0, 16, 16, 1, 1, 255, 255, 255, 8, 8};
  int test_fill  [num_tests] = '{0, 0, 1, 0, 3, 2, 0, 3, 0, 0};
  bit test_gaps  [num_tests] = '{0, 0, 1, 0, 0, 0, 1, 0, 0, 1};
  bit test_poke  [num_tests] = '{0, 0, 0, 0, 0, 0, 0, 0, 1, 0};
  bit test_check [num_tests] = '{0, 1, 1, 1, 1, 1, 1, 1, 1, 1};

  logic                       clk = 1'b0;
  logic                       reset;
  logic                       start;
  logic [klen_w-1:0]          k_len;
  logic                       in_valid;
  logic                       in_ready;
  mm_pkg::elem_vec_t          a_col;
  mm_pkg::elem_vec_t          b_row;
  logic                       busy;
  logic                       done;
  logic [$clog2(n)-1:0]       rd_row;
  mm_pkg::acc_t [n-1:0]       rd_data;
  logic                       reading;

  mm_pkg::elem_t a_m [n][max_k];
  mm_pkg::elem_t b_m [max_k][n];
  logic [31:0]   rng_state = 32'hf0eb2e0d;

  mm_top i_dut (
    .clk(clk), .reset(reset), .start(start), .k_len(k_len),
    .in_valid(in_valid), .in_ready(in_ready), .a_col(a_col), .b_row(b_row),
    .busy(busy), .done(done), .rd_row(rd_row), .rd_data(rd_data)
  );

  mm_checker i_chk (
    .clk(clk), .reset(reset), .start(start), .k_len(k_len),
    .in_valid(in_valid), .in_ready(in_ready), .busy(busy), .done(done),
    .rd_data(rd_data), .rd_row(rd_row), .reading(reading)
  );

  initial begin
    forever #(clk_period / 2) clk = ~clk;
  end

  // xorshift32
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic fill_matrices(input int mode);
    if (mode == 1) begin
      return;
    end
    for (int i = 0; i < n; i++) begin
      for (int s = 0; s < max_k; s++) begin
        case (mode)
          2: begin
            a_m[i][s] = elem_min;
            b_m[s][i] = elem_max;
          end
          3: begin
            a_m[i][s] = elem_min;
            b_m[s][i] = elem_min;
          end
          default: begin
            a_m[i][s] = mm_pkg::elem_t'(next_random());
            b_m[s][i] = mm_pkg::elem_t'(next_random());
          end
        endcase
      end
    end
  endtask

  task automatic run_matrix(input int k, input bit gaps, input bit poke, input bit check);
    mm_pkg::elem_vec_t a_v;
    mm_pkg::elem_vec_t b_v;
    int                step;
    int                gap;
    int                wait_cycles;
    bit                poked;
    step        = 0;
    wait_cycles = 0;
    poked       = 1'b0;
    i_chk.expect_run(k, check, a_m, b_m);
    @(posedge clk);
    start <= 1'b1;
    k_len <= klen_w'(k);
    @(posedge clk);
    start <= 1'b0;
    while (step < k) begin
      gap = gaps ? int'(next_random() % 4) : 0;
      // junk on the data lines while in_valid is low
      repeat (gap) begin
        in_valid <= 1'b0;
        a_col    <= mm_pkg::elem_vec_t'(next_random());
        b_row    <= mm_pkg::elem_vec_t'(next_random());
        @(posedge clk);
      end
      for (int i = 0; i < n; i++) begin
        a_v[i] = a_m[i][step];
        b_v[i] = b_m[step][i];
      end
      in_valid <= 1'b1;
      a_col    <= a_v;
      b_row    <= b_v;
      // restart with another length in the middle of a run
      if (poke && !poked && step == k / 2) begin
        start <= 1'b1;
        k_len <= klen_w'(3);
        poked = 1'b1;
      end
      @(posedge clk);
      start <= 1'b0;
      if (in_ready) begin
        step = step + 1;
      end
    end
    // keep offering data past k_len, none of it may be taken
    in_valid <= 1'b1;
    a_col    <= mm_pkg::elem_vec_t'(next_random());
    b_row    <= mm_pkg::elem_vec_t'(next_random());
    repeat (2) @(posedge clk);
    in_valid <= 1'b0;
    while (!done && wait_cycles < 4 * `MM_DRAIN) begin
      @(posedge clk);
      wait_cycles = wait_cycles + 1;
    end
    if (!done) begin
      i_chk.flag_protocol("no done after the last input step of a run");
    end else begin
      @(posedge clk);
      while (reading) begin
        @(posedge clk);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // watchdog
  ////////////////////////////////////////////////////////////////////////////

  // gaps are at most 3 idle cycles per step
  function automatic int cycle_budget();
    int total;
    total = 0;
    for (int t = 0; t < num_tests; t++) begin
      total = total + test_klen[t] + (test_gaps[t] ? 3 * test_klen[t] : 0);
      total = total + `MM_DRAIN + n + 10;
    end
    return 2 * total + 20;
  endfunction

  initial begin : watchdog
    int budget;
    budget = cycle_budget();
    repeat (budget) @(posedge clk);
    $display("watchdog: the run did not finish within %0d cycles", budget);
    $display("TESTS FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main
    int data_errs;
    int proto_errs;
    reset    = 1'b1;
    start    = 1'b0;
    k_len    = '0;
    in_valid = 1'b0;
    a_col    = '0;
    b_row    = '0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    // quiet window, the checker flags any busy, done or in_ready here
    repeat (5) @(posedge clk);
    for (int t = 0; t < num_tests; t++) begin
      fill_matrices(test_fill[t]);
      run_matrix(test_klen[t], test_gaps[t], test_poke[t], test_check[t]);
    end
    repeat (2) @(posedge clk);
    i_chk.final_check(data_errs, proto_errs);
    $display("data errors: %0d, protocol errors: %0d", data_errs, proto_errs);
    if (data_errs == 0 && proto_errs == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+include
hw/mm_pkg.sv
hw/skew_regs.sv
hw/mac_pe.sv
hw/mac_array.sv
hw/mm_ctrl.sv
hw/mm_top.sv
dv/mm_checker.sv
dv/mm_tb.sv

//--- Makefile
# Verilator build and run of the matrix engine testbench
# any variable below can be set on the make command line

VERILATOR ?= verilator
TOP       ?= mm_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -j 0

SOURCES := $(wildcard hw/*.sv dv/*.sv include/*.svh)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides the result, the simulator exit code is not trusted
run: compile
	./$(BINARY) | tee $(LOG)
	@if grep -q "^TESTS PASSED$$" $(LOG); then \
	  echo "simulation result: pass"; \
	else \
	  echo "simulation result: fail"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
